// File: all.f
+incdir+include
logic/smartnic_pkg.sv
logic/datapath_regs.sv
logic/ingress_classifier.sv
logic/egress_demux.sv
logic/hash2qid.sv
logic/smartnic_datapath.sv
dv/smartnic_datapath_tb.sv

// File: Makefile
# Verilator build and run for the smartnic datapath testbench

VERILATOR ?= verilator
TOP       ?= smartnic_datapath_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(FILELIST) $(SRCS) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ========================================
// expected descriptor at the output
// ========================================

typedef struct packed {
    port_t                port;
    logic [LEN_W-1:0]     len;
    logic [TAG_W-1:0]     tag;
    logic                 rss;
    logic [ENT_W-1:0]     ent;
    logic [QID_WIDTH-1:0] qid;
    // cycle count when the descriptor was driven
    int                   cyc;
} exp_t;

// mirror of the register state
logic [FWD_W-1:0]     m_fwd [NUM_PORTS];
logic [NUM_HOSTS-1:0] m_demux;
logic [QID_WIDTH-1:0] m_qbase [NUM_HOSTS];
logic [QID_WIDTH-1:0] m_vf [NUM_HOSTS][VF_ENTRIES];
logic [31:0]          lfsr_state;

function automatic void model_reset();
    // identity forwarding, rss off, everything else zero
    for (int i = 0; i < NUM_PORTS; i++) begin
        m_fwd[i] = FWD_W'(i);
    end
    m_demux = '0;
    for (int h = 0; h < NUM_HOSTS; h++) begin
        m_qbase[h] = '0;
        for (int e = 0; e < VF_ENTRIES; e++) begin
            m_vf[h][e] = '0;
        end
    end
endfunction

// register map decode, unmapped addresses fall through
function automatic void model_write(logic [REG_ADDR_W-1:0] addr, logic [REG_DATA_W-1:0] data);
    if (addr == DEMUX_SEL_ADDR) begin
        m_demux = data[1:0];
    end else if (addr >= FWD_BASE_ADDR && addr <= FWD_BASE_ADDR + 8'd3) begin
        m_fwd[addr[1:0]] = data[2:0];
    end else if (addr >= QBASE_BASE_ADDR && addr <= QBASE_BASE_ADDR + 8'd1) begin
        m_qbase[addr[0]] = data[QID_WIDTH-1:0];
    end else if (addr >= VF_BASE_ADDR && addr <= VF_BASE_ADDR + 8'h1f) begin
        // addr bit 4 is the host
        m_vf[addr[4]][addr[3:0]] = data[QID_WIDTH-1:0];
    end
endfunction

// table lookup then host redirect
function automatic port_t ref_port(port_t in_p);
    port_t p;
    p = m_fwd[in_p][1:0];
    if (!p[1] && m_demux[p[0]]) begin
        p[1] = 1'b1;
    end
    return p;
endfunction

function automatic logic ref_rss(port_t in_p);
    return m_fwd[in_p][2];
endfunction

function automatic logic [ENT_W-1:0] ref_entropy(port_t in_p, logic [TAG_W-1:0] tag);
    logic [ENT_W-1:0] e;
    e = tag[11:0];
    e[3:0] = e[3:0] ^ tag[15:12];
    e[11:10] = e[11:10] ^ in_p;
    return e;
endfunction

// vf entry plus host base, wraps at QID_WIDTH bits
function automatic logic [QID_WIDTH-1:0] ref_qid(port_t p, logic [ENT_W-1:0] ent);
    logic [QID_WIDTH-1:0] q;
    q = m_vf[p[0]][ent[3:0]] + m_qbase[p[0]];
    return q;
endfunction

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

`endif

// File: dv/smartnic_datapath_tb.sv
`timescale 1ns/1ps

module smartnic_datapath_tb;
    import smartnic_pkg::*;

    localparam int QID_WIDTH   = 12;
    localparam int CYCLE_LIMIT = 5000;

    `include "tb_model.svh"

    logic clk;
    logic rst;
    logic in_valid;
    port_t in_port;
    logic [LEN_W-1:0] in_len;
    logic [TAG_W-1:0] in_tag;
    logic reg_wr;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [REG_DATA_W-1:0] reg_wdata;
    logic out_valid;
    port_t out_port;
    logic [LEN_W-1:0] out_len;
    logic [TAG_W-1:0] out_tag;
    logic out_rss_enable;
    logic [ENT_W-1:0] out_entropy;
    logic [QID_WIDTH-1:0] out_qid;

    exp_t exp_q [$];
    int cycle = 0;
    int n_pass = 0;
    int n_fail = 0;

    smartnic_datapath #(.QID_WIDTH(QID_WIDTH)) uut (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_port(in_port), .in_len(in_len), .in_tag(in_tag),
        .reg_wr(reg_wr), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .out_valid(out_valid), .out_port(out_port), .out_len(out_len), .out_tag(out_tag),
        .out_rss_enable(out_rss_enable), .out_entropy(out_entropy), .out_qid(out_qid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // cycle count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ========================================
    // compare
    // ========================================

    // outputs sampled one edge after they change
    always @(posedge clk) begin
        exp_t e;
        logic bad;
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid at %0t ns with no descriptor outstanding", $time);
                n_fail++;
            end else begin
                e = exp_q.pop_front();
                bad = 1'b0;
                if (out_port !== e.port) begin
                    $display("Fail at %0t ns: out_port %0d, expected %0d", $time, out_port, e.port);
                    bad = 1'b1;
                end
                if (out_len !== e.len || out_tag !== e.tag) begin
                    $display("Fail at %0t ns: len/tag %h/%h, expected %h/%h",
                             $time, out_len, out_tag, e.len, e.tag);
                    bad = 1'b1;
                end
                if (out_rss_enable !== e.rss) begin
                    $display("Fail at %0t ns: out_rss_enable %b, expected %b",
                             $time, out_rss_enable, e.rss);
                    bad = 1'b1;
                end
                if (out_entropy !== e.ent) begin
                    $display("Fail at %0t ns: out_entropy %h, expected %h",
                             $time, out_entropy, e.ent);
                    bad = 1'b1;
                end
                // qid only meaningful toward a host
                if (e.port[1] && out_qid !== e.qid) begin
                    $display("Fail at %0t ns: out_qid %h, expected %h", $time, out_qid, e.qid);
                    bad = 1'b1;
                end
                if (cycle - e.cyc != 3) begin
                    $display("Fail at %0t ns: latency %0d cycles, expected 3",
                             $time, cycle - e.cyc);
                    bad = 1'b1;
                end
                if (bad) n_fail++;
                else n_pass++;
            end
        end
    end

    // ========================================
    // stimulus
    // ========================================

    // inputs for one falling edge plus the expected output
    task automatic drive_cycle(input logic dv, input port_t p, input logic [LEN_W-1:0] len,
                               input logic [TAG_W-1:0] tag, input logic wv,
                               input logic [REG_ADDR_W-1:0] addr,
                               input logic [REG_DATA_W-1:0] data);
        exp_t e;
        in_valid  = dv;
        in_port   = p;
        in_len    = len;
        in_tag    = tag;
        reg_wr    = wv;
        reg_addr  = addr;
        reg_wdata = data;
        if (dv) begin
            e.port = ref_port(p);
            e.len  = len;
            e.tag  = tag;
            e.rss  = ref_rss(p);
            e.ent  = ref_entropy(p, tag);
            e.qid  = ref_qid(e.port, e.ent);
            e.cyc  = cycle;
            exp_q.push_back(e);
        end
        // a write in this cycle only reaches later descriptors
        if (wv) model_write(addr, data);
        @(negedge clk);
    endtask

    task automatic send_desc(input port_t p, input logic [LEN_W-1:0] len,
                             input logic [TAG_W-1:0] tag);
        drive_cycle(1'b1, p, len, tag, 1'b0, '0, '0);
    endtask

    task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [REG_DATA_W-1:0] data);
        drive_cycle(1'b0, '0, '0, '0, 1'b1, addr, data);
    endtask

    // idle until the pipe is empty or 10 cycles pass
    task automatic drain();
        drive_cycle(1'b0, '0, '0, '0, 1'b0, '0, '0);
        for (int i = 0; i < 10 && exp_q.size() != 0; i++) @(negedge clk);
    endtask

    task automatic end_test(input string name, input int fails_before);
        drain();
        if (n_fail == fails_before) $display("%s: done, all descriptors matched", name);
        else $display("%s: done, %0d descriptors wrong", name, n_fail - fails_before);
    endtask

    // ========================================
    // tests
    // ========================================

    task automatic test_forwarding();
        int f0;
        f0 = n_fail;
        // all four cmac to cmac combinations
        for (int a = 0; a < 2; a++) begin
            for (int b = 0; b < 2; b++) begin
                write_reg(FWD_BASE_ADDR, 16'(a));
                write_reg(FWD_BASE_ADDR + 8'd1, 16'(b));
                send_desc(PORT_CMAC0, 14'(100 + a * 4 + b), 16'(16'h1234 + a * 2 + b));
                send_desc(PORT_CMAC1, 14'h3fff, 16'(16'hfedc - a * 2 - b));
            end
        end
        end_test("forwarding", f0);
    endtask

    task automatic test_redirect();
        int f0;
        f0 = n_fail;
        write_reg(FWD_BASE_ADDR + 8'd2, 16'd1);
        write_reg(FWD_BASE_ADDR + 8'd3, 16'd0);
        write_reg(DEMUX_SEL_ADDR, 16'd3);
        for (int i = 0; i < NUM_PORTS; i++) send_desc(2'(i), 14'(64 + i), 16'(16'hbeef + i));
        // only cmac0-bound traffic redirected
        write_reg(DEMUX_SEL_ADDR, 16'd1);
        for (int i = 0; i < NUM_PORTS; i++) send_desc(2'(i), 14'(200 + i), 16'(16'h0f0f + i));
        end_test("host redirect", f0);
    endtask

    task automatic test_rss_qid();
        int f0;
        logic [LEN_W-1:0] len;
        logic [TAG_W-1:0] tag;
        f0 = n_fail;
        write_reg(DEMUX_SEL_ADDR, 16'd0);
        // every port host-bound with rss
        write_reg(FWD_BASE_ADDR, 16'h6);
        write_reg(FWD_BASE_ADDR + 8'd1, 16'h7);
        write_reg(FWD_BASE_ADDR + 8'd2, 16'h7);
        write_reg(FWD_BASE_ADDR + 8'd3, 16'h6);
        write_reg(QBASE_BASE_ADDR, 16'd1);
        write_reg(QBASE_BASE_ADDR + 8'd1, 16'd16);
        // host 1 entries near the top so base 16 wraps
        for (int e = 0; e < VF_ENTRIES; e++) begin
            write_reg(VF_BASE_ADDR + 8'(e), 16'(e * 16'h101));
            write_reg(VF_BASE_ADDR + 8'h10 + 8'(e), 16'(16'hff0 + e));
        end
        for (int i = 0; i < 32; i++) begin
            len = 14'(rand_bits(14));
            tag = 16'(rand_bits(16));
            send_desc(2'(i), len, tag);
        end
        end_test("rss and queue id", f0);
    endtask

    task automatic test_random_stream();
        int f0;
        logic wv;
        logic [2:0] kind;
        logic [REG_ADDR_W-1:0] addr;
        port_t p;
        logic [LEN_W-1:0] len;
        logic [TAG_W-1:0] tag;
        logic [REG_DATA_W-1:0] data;
        f0 = n_fail;
        // back to back descriptors with writes on about a quarter of cycles
        for (int i = 0; i < 500; i++) begin
            wv = (rand_bits(2) == 0);
            kind = 3'(rand_bits(3));
            case (kind)
                3'd0: addr = DEMUX_SEL_ADDR;
                3'd1, 3'd2: addr = FWD_BASE_ADDR + 8'(rand_bits(2));
                3'd3: addr = QBASE_BASE_ADDR + 8'(rand_bits(1));
                3'd7: addr = 8'h80 | 8'(rand_bits(7));
                default: addr = VF_BASE_ADDR + 8'(rand_bits(5));
            endcase
            p    = 2'(rand_bits(2));
            len  = 14'(rand_bits(14));
            tag  = 16'(rand_bits(16));
            data = 16'(rand_bits(16));
            drive_cycle(1'b1, p, len, tag, wv, addr, data);
        end
        end_test("random stream", f0);
    endtask

    initial begin
        int f0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_port = '0;
        in_len = '0;
        in_tag = '0;
        reg_wr = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        lfsr_state = 32'h64df;
        model_reset();
        // two reset edges, then release on the falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // identity table out of reset
        f0 = n_fail;
        for (int i = 0; i < NUM_PORTS; i++) send_desc(2'(i), 14'(10 + i), 16'(16'h1000 * i + 7));
        end_test("reset defaults", f0);
        test_forwarding();
        test_redirect();
        test_rss_qid();
        test_random_stream();

        if (exp_q.size() != 0) begin
            $display("%0d descriptors never came out of the pipeline", exp_q.size());
            n_fail += exp_q.size();
        end
        $display("descriptors passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: logic/smartnic_datapath.sv
`timescale 1ns/1ps

module smartnic_datapath #(
    parameter int QID_WIDTH = 12
) (
    input  logic                               clk,
    input  logic                               rst,
    // descriptor in
    input  logic                               in_valid,
    input  smartnic_pkg::port_t                in_port,
    input  logic [smartnic_pkg::LEN_W-1:0]     in_len,
    input  logic [smartnic_pkg::TAG_W-1:0]     in_tag,
    // register writes
    input  logic                               reg_wr,
    input  logic [smartnic_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [smartnic_pkg::REG_DATA_W-1:0] reg_wdata,
    // descriptor out, three cycles later
    output logic                               out_valid,
    output smartnic_pkg::port_t                out_port,
    output logic [smartnic_pkg::LEN_W-1:0]     out_len,
    output logic [smartnic_pkg::TAG_W-1:0]     out_tag,
    output logic                               out_rss_enable,
    output logic [smartnic_pkg::ENT_W-1:0]     out_entropy,
    output logic [QID_WIDTH-1:0]               out_qid
);
    import smartnic_pkg::*;

    // ========================================
    // config from register block
    // ========================================

    logic [NUM_PORTS*FWD_W-1:0]     fwd_table;
    logic [NUM_HOSTS-1:0]           demux_sel;
    logic [NUM_HOSTS*QID_WIDTH-1:0] qbase;
    logic                           vf_wr;
    logic                           vf_host;
    logic [VF_IDX_W-1:0]            vf_idx;
    logic [QID_WIDTH-1:0]           vf_data;

    // classifier to demux
    logic                           cls_valid;
    port_t                          cls_port;
    logic [LEN_W-1:0]               cls_len;
    logic [TAG_W-1:0]               cls_tag;
    logic                           cls_rss_enable;
    logic [ENT_W-1:0]               cls_entropy;

    // demux to hash2qid
    logic                           dmx_valid;
    port_t                          dmx_port;
    logic [LEN_W-1:0]               dmx_len;
    logic [TAG_W-1:0]               dmx_tag;
    logic                           dmx_rss_enable;
    logic [ENT_W-1:0]               dmx_entropy;

    datapath_regs #(
        .QID_WIDTH (QID_WIDTH)
    ) u_regs (
        .clk       (clk),
        .rst       (rst),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .fwd_table (fwd_table),
        .demux_sel (demux_sel),
        .qbase     (qbase),
        .vf_wr     (vf_wr),
        .vf_host   (vf_host),
        .vf_idx    (vf_idx),
        .vf_data   (vf_data)
    );

    // stage 1
    ingress_classifier u_cls (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_port        (in_port),
        .in_len         (in_len),
        .in_tag         (in_tag),
        .fwd_table      (fwd_table),
        .cls_valid      (cls_valid),
        .cls_port       (cls_port),
        .cls_len        (cls_len),
        .cls_tag        (cls_tag),
        .cls_rss_enable (cls_rss_enable),
        .cls_entropy    (cls_entropy)
    );

    // stage 2
    egress_demux u_dmx (
        .clk            (clk),
        .rst            (rst),
        .cls_valid      (cls_valid),
        .cls_port       (cls_port),
        .cls_len        (cls_len),
        .cls_tag        (cls_tag),
        .cls_rss_enable (cls_rss_enable),
        .cls_entropy    (cls_entropy),
        .demux_sel      (demux_sel),
        .dmx_valid      (dmx_valid),
        .dmx_port       (dmx_port),
        .dmx_len        (dmx_len),
        .dmx_tag        (dmx_tag),
        .dmx_rss_enable (dmx_rss_enable),
        .dmx_entropy    (dmx_entropy)
    );

    // stage 3
    hash2qid #(
        .QID_WIDTH (QID_WIDTH)
    ) u_h2q (
        .clk            (clk),
        .rst            (rst),
        .dmx_valid      (dmx_valid),
        .dmx_port       (dmx_port),
        .dmx_len        (dmx_len),
        .dmx_tag        (dmx_tag),
        .dmx_rss_enable (dmx_rss_enable),
        .dmx_entropy    (dmx_entropy),
        .qbase          (qbase),
        .vf_wr          (vf_wr),
        .vf_host        (vf_host),
        .vf_idx         (vf_idx),
        .vf_data        (vf_data),
        .out_valid      (out_valid),
        .out_port       (out_port),
        .out_len        (out_len),
        .out_tag        (out_tag),
        .out_rss_enable (out_rss_enable),
        .out_entropy    (out_entropy),
        .out_qid        (out_qid)
    );

endmodule

// File: logic/hash2qid.sv
`timescale 1ns/1ps

module hash2qid #(
    parameter int QID_WIDTH = 12
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         dmx_valid,
    input  smartnic_pkg::port_t                          dmx_port,
    input  logic [smartnic_pkg::LEN_W-1:0]               dmx_len,
    input  logic [smartnic_pkg::TAG_W-1:0]               dmx_tag,
    input  logic                                         dmx_rss_enable,
    input  logic [smartnic_pkg::ENT_W-1:0]               dmx_entropy,
    input  logic [smartnic_pkg::NUM_HOSTS*QID_WIDTH-1:0] qbase,
    input  logic                                         vf_wr,
    input  logic                                         vf_host,
    input  logic [smartnic_pkg::VF_IDX_W-1:0]            vf_idx,
    input  logic [QID_WIDTH-1:0]                         vf_data,
    output logic                                         out_valid,
    output smartnic_pkg::port_t                          out_port,
    output logic [smartnic_pkg::LEN_W-1:0]               out_len,
    output logic [smartnic_pkg::TAG_W-1:0]               out_tag,
    output logic                                         out_rss_enable,
    output logic [smartnic_pkg::ENT_W-1:0]               out_entropy,
    output logic [QID_WIDTH-1:0]                         out_qid
);
    import smartnic_pkg::*;

    // queue offsets, one table per host
    logic [QID_WIDTH-1:0] vf_table [NUM_HOSTS][VF_ENTRIES];

    logic                 host_sel;
    logic [VF_IDX_W-1:0]  tbl_idx;
    logic [QID_WIDTH-1:0] vf_offset;
    logic [QID_WIDTH-1:0] host_base;
    logic [QID_WIDTH-1:0] qid;

    // ========================================
    // vf table writes
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int h = 0; h < NUM_HOSTS; h++) begin
                for (int e = 0; e < VF_ENTRIES; e++) begin
                    vf_table[h][e] <= '0;
                end
            end
        end else if (vf_wr) begin
            vf_table[vf_host][vf_idx] <= vf_data;
        end
    end

    // ========================================
    // queue id
    // ========================================

    always_comb begin
        // port number picks the host, cmac ports give a don't-care qid
        host_sel  = dmx_port[0];
        tbl_idx   = dmx_entropy[VF_IDX_W-1:0];
        vf_offset = vf_table[host_sel][tbl_idx];
        host_base = qbase[host_sel*QID_WIDTH +: QID_WIDTH];
        // wraps mod 2**QID_WIDTH
        qid       = vf_offset + host_base;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= dmx_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dmx_valid) begin
            out_port       <= dmx_port;
            out_len        <= dmx_len;
            out_tag        <= dmx_tag;
            out_rss_enable <= dmx_rss_enable;
            out_entropy    <= dmx_entropy;
            out_qid        <= qid;
        end
    end

endmodule

// File: logic/egress_demux.sv
`timescale 1ns/1ps

module egress_demux (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cls_valid,
    input  smartnic_pkg::port_t               cls_port,
    input  logic [smartnic_pkg::LEN_W-1:0]    cls_len,
    input  logic [smartnic_pkg::TAG_W-1:0]    cls_tag,
    input  logic                              cls_rss_enable,
    input  logic [smartnic_pkg::ENT_W-1:0]    cls_entropy,
    input  logic [smartnic_pkg::NUM_HOSTS-1:0] demux_sel,
    output logic                              dmx_valid,
    output smartnic_pkg::port_t               dmx_port,
    output logic [smartnic_pkg::LEN_W-1:0]    dmx_len,
    output logic [smartnic_pkg::TAG_W-1:0]    dmx_tag,
    output logic                              dmx_rss_enable,
    output logic [smartnic_pkg::ENT_W-1:0]    dmx_entropy
);
    import smartnic_pkg::*;

    port_t final_port;

    // ========================================
    // host redirect
    // ========================================

    always_comb begin
        final_port = cls_port;
        // cmac n bound, select bit n set
        if (!cls_port[HOST_BIT] && demux_sel[cls_port[0]]) begin
            final_port[HOST_BIT] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dmx_valid <= 1'b0;
        end else begin
            dmx_valid <= cls_valid;
        end
    end

    // rest of the descriptor rides along
    always_ff @(posedge clk) begin
        if (cls_valid) begin
            dmx_port       <= final_port;
            dmx_len        <= cls_len;
            dmx_tag        <= cls_tag;
            dmx_rss_enable <= cls_rss_enable;
            dmx_entropy    <= cls_entropy;
        end
    end

endmodule

// File: logic/ingress_classifier.sv
`timescale 1ns/1ps

module ingress_classifier (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 in_valid,
    input  smartnic_pkg::port_t                                  in_port,
    input  logic [smartnic_pkg::LEN_W-1:0]                       in_len,
    input  logic [smartnic_pkg::TAG_W-1:0]                       in_tag,
    input  logic [smartnic_pkg::NUM_PORTS*smartnic_pkg::FWD_W-1:0] fwd_table,
    output logic                                                 cls_valid,
    output smartnic_pkg::port_t                                  cls_port,
    output logic [smartnic_pkg::LEN_W-1:0]                       cls_len,
    output logic [smartnic_pkg::TAG_W-1:0]                       cls_tag,
    output logic                                                 cls_rss_enable,
    output logic [smartnic_pkg::ENT_W-1:0]                       cls_entropy
);
    import smartnic_pkg::*;

    logic [FWD_W-1:0] fwd_entry;
    port_t            egr_port;
    logic             rss_enable;
    logic [ENT_W-1:0] entropy;

    // ========================================
    // forwarding lookup
    // ========================================

    // table indexed by ingress port
    always_comb begin
        fwd_entry  = fwd_table[in_port*FWD_W +: FWD_W];
        egr_port   = fwd_entry[$bits(port_t)-1:0];
        rss_enable = fwd_entry[FWD_RSS_BIT];
    end

    // ========================================
    // rss entropy
    // ========================================

    always_comb begin
        // low tag bits as the base
        entropy = in_tag[ENT_W-1:0];
        // fold top nibble of tag into the low nibble
        entropy[TAG_W-ENT_W-1:0] = entropy[TAG_W-ENT_W-1:0] ^ in_tag[TAG_W-1:ENT_W];
        // ingress port into the top two bits
        entropy[ENT_W-1:ENT_W-$bits(port_t)] =
            entropy[ENT_W-1:ENT_W-$bits(port_t)] ^ in_port;
    end

    // valid with reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cls_valid <= 1'b0;
        end else begin
            cls_valid <= in_valid;
        end
    end

    // payload captured only on a valid descriptor
    always_ff @(posedge clk) begin
        if (in_valid) begin
            cls_port       <= egr_port;
            cls_len        <= in_len;
            cls_tag        <= in_tag;
            cls_rss_enable <= rss_enable;
            cls_entropy    <= entropy;
        end
    end

endmodule

// File: logic/datapath_regs.sv
`timescale 1ns/1ps

module datapath_regs #(
    parameter int QID_WIDTH = 12
) (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 reg_wr,
    input  logic [smartnic_pkg::REG_ADDR_W-1:0]                  reg_addr,
    input  logic [smartnic_pkg::REG_DATA_W-1:0]                  reg_wdata,
    output logic [smartnic_pkg::NUM_PORTS*smartnic_pkg::FWD_W-1:0] fwd_table,
    output logic [smartnic_pkg::NUM_HOSTS-1:0]                   demux_sel,
    output logic [smartnic_pkg::NUM_HOSTS*QID_WIDTH-1:0]         qbase,
    output logic                                                 vf_wr,
    output logic                                                 vf_host,
    output logic [smartnic_pkg::VF_IDX_W-1:0]                    vf_idx,
    output logic [QID_WIDTH-1:0]                                 vf_data
);
    import smartnic_pkg::*;

    localparam int FWD_SEL_W = $clog2(NUM_PORTS);
    localparam int QB_SEL_W  = $clog2(NUM_HOSTS);

    logic                              hit_demux;
    logic                              hit_fwd;
    logic                              hit_qbase;
    logic                              hit_vf;
    logic [NUM_HOSTS-1:0]              demux_q;
    logic [NUM_HOSTS*QID_WIDTH-1:0]    qbase_q;
    logic [NUM_HOSTS*QID_WIDTH-1:0]    qbase_d1;
    logic                              vf_wr_d1;
    logic                              vf_host_d1;
    logic [VF_IDX_W-1:0]               vf_idx_d1;
    logic [QID_WIDTH-1:0]              vf_data_d1;

    // address decode against the map
    always_comb begin
        hit_demux = reg_wr && (reg_addr == DEMUX_SEL_ADDR);
        hit_fwd   = reg_wr && (reg_addr[REG_ADDR_W-1:FWD_SEL_W] ==
                               FWD_BASE_ADDR[REG_ADDR_W-1:FWD_SEL_W]);
        hit_qbase = reg_wr && (reg_addr[REG_ADDR_W-1:QB_SEL_W] ==
                               QBASE_BASE_ADDR[REG_ADDR_W-1:QB_SEL_W]);
        // vf range spans host bit plus index bits
        hit_vf    = reg_wr && (reg_addr[REG_ADDR_W-1:VF_IDX_W+1] ==
                               VF_BASE_ADDR[REG_ADDR_W-1:VF_IDX_W+1]);
    end

    // ========================================
    // config registers
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            // identity forwarding, rss off
            for (int i = 0; i < NUM_PORTS; i++) begin
                fwd_table[i*FWD_W +: FWD_W] <= FWD_W'(i);
            end
            demux_q <= '0;
            qbase_q <= '0;
        end else begin
            if (hit_demux) begin
                demux_q <= reg_wdata[NUM_HOSTS-1:0];
            end
            if (hit_fwd) begin
                fwd_table[reg_addr[FWD_SEL_W-1:0]*FWD_W +: FWD_W] <= reg_wdata[FWD_W-1:0];
            end
            if (hit_qbase) begin
                qbase_q[reg_addr[QB_SEL_W-1:0]*QID_WIDTH +: QID_WIDTH] <=
                    reg_wdata[QID_WIDTH-1:0];
            end
        end
    end

    // ========================================
    // stage alignment
    // ========================================

    // later stages see a write only from the descriptor after it
    // demux sits one stage deep, hash2qid two
    always_ff @(posedge clk) begin
        if (rst) begin
            demux_sel <= '0;
            qbase_d1  <= '0;
            qbase     <= '0;
            vf_wr_d1  <= 1'b0;
            vf_wr     <= 1'b0;
        end else begin
            demux_sel <= demux_q;
            qbase_d1  <= qbase_q;
            qbase     <= qbase_d1;
            vf_wr_d1  <= hit_vf;
            vf_wr     <= vf_wr_d1;
        end
    end

    // vf write payload follows the strobe
    always_ff @(posedge clk) begin
        vf_host_d1 <= reg_addr[VF_IDX_W];
        vf_idx_d1  <= reg_addr[VF_IDX_W-1:0];
        vf_data_d1 <= reg_wdata[QID_WIDTH-1:0];
        vf_host    <= vf_host_d1;
        vf_idx     <= vf_idx_d1;
        vf_data    <= vf_data_d1;
    end

endmodule

// File: logic/smartnic_pkg.sv
package smartnic_pkg;

    // ========================================
    // port codes
    // ========================================

    // bit 1 marks a host port, bit 0 is the port number
    typedef logic [1:0] port_t;

    localparam port_t PORT_CMAC0 = 2'd0;
    localparam port_t PORT_CMAC1 = 2'd1;
    localparam port_t PORT_HOST0 = 2'd2;
    localparam port_t PORT_HOST1 = 2'd3;

    localparam int HOST_BIT  = 1;
    localparam int NUM_PORTS = 4;
    localparam int NUM_HOSTS = 2;

    // ========================================
    // descriptor and table widths
    // ========================================

    localparam int LEN_W = 14;
    localparam int TAG_W = 16;
    localparam int ENT_W = 12;

    // vf table indexed by entropy low bits
    localparam int VF_ENTRIES = 16;
    localparam int VF_IDX_W   = $clog2(VF_ENTRIES);

    // forwarding entry is {rss_enable, egress port}
    localparam int FWD_W       = 3;
    localparam int FWD_RSS_BIT = 2;

    // ========================================
    // register bus and map
    // ========================================

    localparam int REG_ADDR_W = 8;
    localparam int REG_DATA_W = 16;

    localparam logic [REG_ADDR_W-1:0] DEMUX_SEL_ADDR  = 8'h00;
    // one entry per ingress port, 0x10..0x13
    localparam logic [REG_ADDR_W-1:0] FWD_BASE_ADDR   = 8'h10;
    // host 0 and host 1 queue base, 0x20..0x21
    localparam logic [REG_ADDR_W-1:0] QBASE_BASE_ADDR = 8'h20;
    // addr bit 4 picks the host, bits 3..0 the entry
    localparam logic [REG_ADDR_W-1:0] VF_BASE_ADDR    = 8'h40;

endpackage
